//--- verilog.f
+incdir+include
rtl/cpu_pkg.sv
rtl/cpu_alu.sv
rtl/cpu_irq_ctrl.sv
rtl/cpu_regfile.sv
rtl/cpu_sequencer.sv
rtl/cpu.sv
sim/cpu_clkgen.sv
sim/cpu_checker.sv
sim/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= cpu_tb
RTL_TOP   ?= cpu
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/cpu_tb.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_tb import cpu_pkg::*; ();

  typedef struct packed {
    logic [2:0] test;
    word_t      addr;
    word_t      data;
  } store_t;

  localparam word_t JUMP_TO  = 16'h0048;
  localparam word_t OUT_ADDR = 16'h007F;
  localparam word_t SRC_ADDR = 16'h007E;
  localparam word_t IRQ_ADDR = 16'h007C;
  localparam word_t MARKER   = 16'h003C;

  logic   clk;
  logic   reset;
  word_t  ram_rdata;
  word_t  ram_wdata;
  word_t  ram_addr;
  logic   we;
  logic   re;
  logic   hlt;
  logic   uart_intr;
  logic   page_fault;
  word_t  mem [0:255];
  store_t exp_q [$];
  integer seed = 69;
  int     fails [6];
  int     checks;
  int     prog_len;
  word_t  pc_w;
  word_t  irq_at [3];
  logic   prog_ready;
  logic   irq_off;
  logic   fetched;
  logic [2:0] cur_test;
  string  names [6] = '{"reset", "alu", "load_store", "skip", "interrupts", "halt"};

  cpu_clkgen clkgen_i (.clk(clk), .reset(reset));

  cpu cpu_i (
    .clk(clk), .reset(reset), .ram_rdata(ram_rdata), .ram_wdata(ram_wdata),
    .ram_addr(ram_addr), .we(we), .re(re), .hlt(hlt),
    .uart_intr(uart_intr), .page_fault(page_fault)
  );

  bind cpu cpu_checker cpu_checker_i (
    .clk(clk), .reset(reset), .we(we), .re(re), .hlt(hlt), .irq_ack(irq_ack),
    .irq_en(irq_en), .ram_addr(ram_addr)
  );

  // Synchronous memory, data one cycle after re
  always @(posedge clk) begin
    if (re) ram_rdata <= mem[ram_addr[7:0]];
    if (we) mem[ram_addr[7:0]] <= ram_wdata;
  end

  function automatic word_t sext(logic [7:0] b);
    return {{8{b[7]}}, b};
  endfunction

  function automatic word_t ldi_word(int rd, logic [7:0] imm);
    return {4'h1, rd[2:0], 1'b0, imm};
  endfunction

  function automatic word_t alu_word(int rd, int rs, int rt, int f);
    return {4'h2, rd[2:0], rs[2:0], rt[2:0], f[2:0]};
  endfunction

  function automatic word_t ld_word(int rd, int rs);
    return {4'h3, rd[2:0], rs[2:0], 6'd0};
  endfunction

  // Address in rs, data in rt
  function automatic word_t st_word(int rs, int rt);
    return {4'h4, 3'd0, rs[2:0], rt[2:0], 3'd0};
  endfunction

  function automatic word_t skip_word(int rs, int c);
    return {4'h5, 3'd0, rs[2:0], 3'd0, c[2:0]};
  endfunction

  function automatic word_t setcr_word(logic [7:0] imm);
    return {8'h60, imm};
  endfunction

  function automatic word_t alu_model(int f, word_t a, word_t b);
    case (f)
      0: return a + b;
      1: return a - b;
      2: return a & b;
      3: return a | b;
      4: return a ^ b;
      5: return ~a;
      6: return a << (b & 16'h000F);
      default: return a >> (b & 16'h000F);
    endcase
  endfunction

  function automatic logic cond_holds(int c, word_t v);
    logic z;
    logic n;
    z = (v == 16'h0000);
    n = v[15];
    case (c)
      0: return z;
      1: return !z;
      2: return n;
      3: return z || n;
      4: return !z && !n;
      default: return !n;
    endcase
  endfunction

  // Hop over the handler area with a write to R7
  task automatic make_room(input int n);
    if (pc_w < 16'h0040 && pc_w + n > 16'h003F) begin
      mem[pc_w[7:0]] = ldi_word(7, JUMP_TO[7:0]);
      pc_w = JUMP_TO;
      prog_len++;
    end
  endtask

  task automatic emit(input word_t w);
    make_room(1);
    mem[pc_w[7:0]] = w;
    pc_w = pc_w + 16'd1;
    prog_len++;
  endtask

  task automatic expect_store(input int test, input word_t addr, input word_t data);
    exp_q.push_back('{test: test[2:0], addr: addr, data: data});
  endtask

  task automatic nop_region(input int k);
    make_room(1);
    irq_at[k] = pc_w;
    repeat (6) emit(16'h0000);
  endtask

  task automatic build_program;
    logic [7:0] ra;
    logic [7:0] rb;
    logic [7:0] vals [3];
    for (int i = 0; i < 256; i++) mem[i] = {i[7:0] ^ 8'h5A, i[7:0]};
    pc_w = `CPU_RESET_PC;
    prog_len = 0;
    emit(ldi_word(6, OUT_ADDR[7:0]));
    emit(ldi_word(4, MARKER[7:0]));
    ra = $random(seed);
    rb = $random(seed);
    emit(ldi_word(1, ra));
    emit(ldi_word(2, rb));
    for (int f = 0; f < 8; f++) begin
      emit(alu_word(3, 1, 2, f));
      emit(st_word(6, 3));
      expect_store(1, OUT_ADDR, alu_model(f, sext(ra), sext(rb)));
    end
    mem[SRC_ADDR[7:0]] = $random(seed);
    emit(ldi_word(5, SRC_ADDR[7:0]));
    emit(ld_word(3, 5));
    emit(st_word(6, 3));
    expect_store(2, OUT_ADDR, mem[SRC_ADDR[7:0]]);
    // Zero, negative, positive
    vals[0] = 8'h00;
    vals[1] = 8'h80;
    vals[2] = ($random(seed) & 8'h3F) + 8'd1;
    for (int k = 0; k < 3; k++) begin
      emit(ldi_word(1, vals[k]));
      for (int c = 0; c < 6; c++) begin
        make_room(2);
        emit(skip_word(1, c));
        emit(st_word(6, 4));
        if (!cond_holds(c, sext(vals[k]))) expect_store(3, OUT_ADDR, MARKER);
      end
    end
    emit(setcr_word(8'h08));
    nop_region(0);
    expect_store(4, IRQ_ADDR, `CPU_TRAP_UART);
    nop_region(1);
    expect_store(4, IRQ_ADDR, `CPU_TRAP_PGFAULT);
    expect_store(4, IRQ_ADDR, `CPU_TRAP_UART);
    emit(setcr_word(8'h00));
    nop_region(2);
    emit(16'hF000);
    // Handler runs in bank 1
    mem[8'h40] = ldi_word(6, IRQ_ADDR[7:0]);
    mem[8'h41] = st_word(6, 1);
    mem[8'h42] = 16'h7000;
    if (pc_w > 16'h007B) begin
      $display("program image runs into the data area at %h", pc_w);
      fails[0]++;
    end
  endtask

  task automatic report(input int id);
    $display("test %0d %s: %s (%0d errors)", id, names[id],
             fails[id] == 0 ? "ok" : "failed", fails[id]);
  endtask

  task automatic wait_fetch(input word_t addr);
    do @(posedge clk); while (!(re && ram_addr == addr));
  endtask

  task automatic pulse_irq(input logic u, input logic p);
    @(posedge clk);
    uart_intr  <= u;
    page_fault <= p;
    repeat (2) @(posedge clk);
    uart_intr  <= 1'b0;
    page_fault <= 1'b0;
  endtask

  always @(posedge clk) begin
    store_t e;
    if (reset) begin
      assert (!we && !re && !hlt) else begin
        $display("MISMATCH we/re/hlt in reset: we=%h re=%h hlt=%h", we, re, hlt);
        fails[0]++;
      end
    end else begin
      if (re && !fetched) begin
        fetched = 1'b1;
        checks++;
        assert (ram_addr == `CPU_RESET_PC) else begin
          $display("MISMATCH ram_addr: got %h expected %h", ram_addr, `CPU_RESET_PC);
          fails[0]++;
        end
        report(0);
      end
      if (irq_off && re) begin
        assert (ram_addr != `CPU_IRQ_VECTOR) else begin
          $display("vector fetched while interrupts were disabled");
          fails[4]++;
        end
      end
      if (we) begin
        if (exp_q.size() == 0) begin
          $display("store of %h to %h when none was expected", ram_wdata, ram_addr);
          fails[cur_test]++;
        end else begin
          e = exp_q.pop_front();
          cur_test = e.test;
          checks++;
          assert (ram_addr == e.addr) else begin
            $display("MISMATCH ram_addr: got %h expected %h", ram_addr, e.addr);
            fails[e.test]++;
          end
          assert (ram_wdata == e.data) else begin
            $display("MISMATCH ram_wdata: got %h expected %h", ram_wdata, e.data);
            fails[e.test]++;
          end
          if ((exp_q.size() == 0 || exp_q[0].test != e.test) && e.test < 4) report(e.test);
        end
      end
    end
  end

  initial begin
    int total;
    ram_rdata  = '0;
    uart_intr  = 1'b0;
    page_fault = 1'b0;
    irq_off    = 1'b0;
    fetched    = 1'b0;
    cur_test   = 3'd0;
    checks     = 0;
    prog_ready = 1'b0;
    build_program();
    prog_ready = 1'b1;
    @(negedge reset);
    wait_fetch(irq_at[0]);
    pulse_irq(1'b1, 1'b0);
    wait_fetch(irq_at[1]);
    pulse_irq(1'b1, 1'b1);
    wait_fetch(irq_at[2]);
    irq_off = 1'b1;
    pulse_irq(1'b1, 1'b0);
    wait (hlt);
    report(4);
    repeat (8) begin
      @(posedge clk);
      checks++;
      assert (hlt && !re && !we) else begin
        $display("core left the halted state or accessed memory after HLT");
        fails[5]++;
      end
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected stores never happened", exp_q.size());
      fails[exp_q[0].test]++;
    end
    report(5);
    total = 0;
    foreach (fails[i]) total += fails[i];
    $display("tests: %0d, checks: %0d, errors: %0d", 6, checks, total);
    if (total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Four cycles per instruction, four times over
  initial begin
    wait (prog_ready);
    @(negedge reset);
    repeat (prog_len * 4 * 4) @(posedge clk);
    $display("watchdog expired before the core halted");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- sim/cpu_checker.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_checker import cpu_pkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       we,
  input logic       re,
  input logic       hlt,
  input logic       irq_ack,
  input logic       irq_en,
  input word_t      ram_addr
);

  a_halt_sticky: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
    else $error("hlt dropped without reset");

  // A halted core stays off the memory bus
  a_halt_quiet: assert property (@(posedge clk) disable iff (reset) hlt |=> !re && !we)
    else $error("memory access while halted");

  // Entry masks further interrupts, then the handler fetch
  a_ack_clears_en: assert property (@(posedge clk) disable iff (reset) irq_ack |=> !irq_en)
    else $error("interrupts still enabled after entry");

  a_vector_fetch: assert property (@(posedge clk) disable iff (reset)
    irq_ack |=> re && ram_addr == `CPU_IRQ_VECTOR)
    else $error("no vector fetch after interrupt entry");

endmodule

//--- sim/cpu_clkgen.sv
`timescale 1ns/10ps

module cpu_clkgen (
  output logic clk,
  output logic reset
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

//--- rtl/cpu.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu import cpu_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  word_t ram_rdata,
  output word_t ram_wdata,
  output word_t ram_addr,
  output logic  we,
  output logic  re,
  output logic  hlt,
  input  logic  uart_intr,
  input  logic  page_fault
);

  ctrl_t      ctrl;
  cpu_state_t state;
  word_t      ir_q;
  word_t      mdr_q;
  word_t      mar_q;
  word_t      cr_q;
  word_t      instr;
  word_t      imm_ext;
  word_t      rd_a;
  word_t      rd_b;
  word_t      pc;
  word_t      op_a;
  word_t      op_b;
  word_t      alu_result;
  word_t      mdr_d;
  logic       alu_cond_true;
  logic       irq_ack;
  logic       irq_pending;
  logic       bank;
  logic       irq_en;
  logic [3:0] trap_nr;

  function automatic word_t pick_operand(op_sel_t sel, word_t ra, word_t rb);
    case (sel)
      OPS_REGB: return rb;
      default:  return ra;
    endcase
  endfunction

  // Decode straight off the bus while IR is being loaded
  assign instr   = (state == DECODE) ? ram_rdata : ir_q;
  assign imm_ext = {{8{instr[7]}}, instr[7:0]};
  assign bank    = cr_q[`CPU_CR_BANK];
  assign irq_en  = cr_q[`CPU_CR_IRQ_EN];

  cpu_sequencer u_seq (
    .clk(clk), .reset(reset), .instr(instr), .irq_pending(irq_pending), .irq_en(irq_en),
    .skip(alu_cond_true), .ctrl(ctrl), .state(state), .irq_ack(irq_ack)
  );

  cpu_regfile u_regfile (
    .clk(clk), .reset(reset), .bank(bank), .rd_a_idx(ctrl.rd_a_idx),
    .rd_b_idx(ctrl.rd_b_idx), .wr_idx(ctrl.wr_idx), .wr_data(mdr_d), .we(ctrl.reg_load),
    .pc_incr(ctrl.pc_incr), .pc_skip(ctrl.pc_skip), .irq_entry(irq_ack), .trap_nr(trap_nr),
    .rd_a(rd_a), .rd_b(rd_b), .pc(pc)
  );

  cpu_alu u_alu (
    .a(op_a), .b(op_b), .func(ctrl.alu_func), .cond(ctrl.cond),
    .result(alu_result), .cond_true(alu_cond_true)
  );

  cpu_irq_ctrl u_irq (
    .clk(clk), .reset(reset), .uart_intr(uart_intr), .page_fault(page_fault),
    .irq_ack(irq_ack), .irq_pending(irq_pending), .trap_nr(trap_nr)
  );

  assign op_a = pick_operand(ctrl.op_a_sel, rd_a, rd_b);
  assign op_b = pick_operand(ctrl.op_b_sel, rd_a, rd_b);

  // Same mux feeds MDR and the register write port
  always_comb begin
    case (ctrl.mdr_sel)
      MDRS_IMM: mdr_d = imm_ext;
      MDRS_RAM: mdr_d = ram_rdata;
      default:  mdr_d = alu_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ir_q <= '0;
    end else if (ctrl.ir_load) begin
      ir_q <= ram_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.mdr_load) begin
      mdr_q <= mdr_d;
    end
    if (ctrl.mar_load) begin
      mar_q <= rd_a;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cr_q <= '0;
    end else if (irq_ack) begin
      cr_q[`CPU_CR_BANK]   <= 1'b1;
      cr_q[`CPU_CR_IRQ_EN] <= 1'b0;
    end else if (ctrl.reti) begin
      cr_q[`CPU_CR_BANK]   <= 1'b0;
      cr_q[`CPU_CR_IRQ_EN] <= 1'b1;
    end else if (ctrl.cr_write) begin
      // Bank only moves on entry and return
      cr_q               <= {8'h00, instr[7:0]};
      cr_q[`CPU_CR_BANK] <= bank;
    end
  end

  assign ram_addr  = (state == FETCH) ? pc : mar_q;
  assign ram_wdata = mdr_q;
  assign we        = ctrl.ram_load;
  assign re        = ctrl.re;
  assign hlt       = ctrl.halt;

endmodule

//--- rtl/cpu_sequencer.sv
`timescale 1ns/10ps

module cpu_sequencer import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  word_t      instr,
  input  logic       irq_pending,
  input  logic       irq_en,
  input  logic       skip,
  output ctrl_t      ctrl,
  output cpu_state_t state,
  output logic       irq_ack
);

  cpu_state_t state_q;
  cpu_state_t state_d;
  opcode_t    op;
  logic       take_irq;
  logic       skip_q;

  assign op       = opcode_t'(instr[15:12]);
  assign take_irq = (state_q == FETCH) && irq_pending && irq_en;
  assign irq_ack  = take_irq;
  assign state    = state_q;

  always_comb begin
    case (state_q)
      // An accepted interrupt costs one extra FETCH cycle
      FETCH:   state_d = take_irq ? FETCH : DECODE;
      DECODE:  state_d = MEM;
      MEM:     state_d = EXEC;
      // HLT parks the machine in EXEC
      EXEC:    state_d = (op == OP_HLT) ? EXEC : FETCH;
      default: state_d = FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= FETCH;
      skip_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (ctrl.cond_chk) begin
        skip_q <= skip;
      end
    end
  end

  always_comb begin
    ctrl          = '0;
    ctrl.rd_a_idx = instr[8:6];
    ctrl.rd_b_idx = instr[5:3];
    ctrl.wr_idx   = instr[11:9];
    ctrl.op_a_sel = OPS_REGA;
    ctrl.op_b_sel = OPS_REGB;
    ctrl.mdr_sel  = MDRS_ALU;
    ctrl.alu_func = alu_func_t'(instr[2:0]);
    ctrl.cond     = cond_t'(instr[2:0]);
    case (state_q)
      FETCH: begin
        // No fetch while reset is held
        ctrl.re = !take_irq && !reset;
      end
      DECODE: begin
        ctrl.ir_load  = 1'b1;
        ctrl.mar_load = (op == OP_LD) || (op == OP_ST);
        if (op == OP_ST) begin
          // rt OR rt gives rt, parked in MDR for the write
          ctrl.mdr_load = 1'b1;
          ctrl.op_a_sel = OPS_REGB;
          ctrl.alu_func = ALU_OR;
        end
      end
      MEM: begin
        case (op)
          OP_LD:   ctrl.re = 1'b1;
          OP_ST:   ctrl.ram_load = 1'b1;
          OP_SKIP: begin
            // Flags come from rs passed through the ALU
            ctrl.cond_chk = 1'b1;
            ctrl.op_b_sel = OPS_REGA;
            ctrl.alu_func = ALU_OR;
          end
          default: ;
        endcase
      end
      EXEC: begin
        ctrl.pc_incr = 1'b1;
        case (op)
          OP_LDI: begin
            ctrl.reg_load = 1'b1;
            ctrl.mdr_sel  = MDRS_IMM;
          end
          OP_ALU:   ctrl.reg_load = 1'b1;
          OP_LD: begin
            ctrl.reg_load = 1'b1;
            ctrl.mdr_load = 1'b1;
            ctrl.mdr_sel  = MDRS_RAM;
          end
          OP_SKIP:  ctrl.pc_skip = skip_q;
          OP_SETCR: ctrl.cr_write = 1'b1;
          OP_RETI:  ctrl.reti = 1'b1;
          OP_HLT: begin
            ctrl.pc_incr = 1'b0;
            ctrl.halt    = 1'b1;
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

//--- rtl/cpu_regfile.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_regfile import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       bank,
  input  reg_idx_t   rd_a_idx,
  input  reg_idx_t   rd_b_idx,
  input  reg_idx_t   wr_idx,
  input  word_t      wr_data,
  input  logic       we,
  input  logic       pc_incr,
  input  logic       pc_skip,
  input  logic       irq_entry,
  input  logic [3:0] trap_nr,
  output word_t      rd_a,
  output word_t      rd_b,
  output word_t      pc
);

  // Index 0-7 is bank 0, 8-15 is bank 1
  word_t      regs [0:15];
  logic [3:0] pc_addr;
  word_t      pc_next;

  assign pc_addr = {bank, 3'd7};
  assign pc      = regs[pc_addr];
  assign rd_a    = regs[{bank, rd_a_idx}];
  assign rd_b    = regs[{bank, rd_b_idx}];

  // A taken SKIP steps over the next word
  assign pc_next = pc + (pc_skip ? 16'd2 : 16'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      regs[7]  <= `CPU_RESET_PC;
      regs[15] <= `CPU_RESET_PC;
    end else if (irq_entry) begin
      // Bank 1 R1 gets the trap number, bank 1 PC the vector
      regs[9]  <= {12'h000, trap_nr};
      regs[15] <= `CPU_IRQ_VECTOR;
    end else begin
      if (pc_incr) begin
        regs[pc_addr] <= pc_next;
      end
      // Explicit write to R7 overrides the increment
      if (we) begin
        regs[{bank, wr_idx}] <= wr_data;
      end
    end
  end

endmodule

//--- rtl/cpu_irq_ctrl.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_irq_ctrl (
  input  logic       clk,
  input  logic       reset,
  input  logic       uart_intr,
  input  logic       page_fault,
  input  logic       irq_ack,
  output logic       irq_pending,
  output logic [3:0] trap_nr
);

  logic uart_q;
  logic pf_q;
  logic uart_pend;
  logic pf_pend;
  logic uart_rise;
  logic pf_rise;
  logic clr_uart;
  logic clr_pf;

  assign uart_rise = uart_intr && !uart_q;
  assign pf_rise   = page_fault && !pf_q;

  // Ack serves only the source currently shown in trap_nr
  assign clr_pf   = irq_ack && pf_pend;
  assign clr_uart = irq_ack && !pf_pend;

  always_ff @(posedge clk) begin
    if (reset) begin
      uart_q    <= 1'b0;
      pf_q      <= 1'b0;
      uart_pend <= 1'b0;
      pf_pend   <= 1'b0;
    end else begin
      uart_q    <= uart_intr;
      pf_q      <= page_fault;
      // New edge wins over a clear in the same cycle
      pf_pend   <= (pf_pend && !clr_pf) || pf_rise;
      uart_pend <= (uart_pend && !clr_uart) || uart_rise;
    end
  end

  assign irq_pending = uart_pend || pf_pend;

  // Page fault first
  always_comb begin
    if (pf_pend) begin
      trap_nr = `CPU_TRAP_PGFAULT;
    end else if (uart_pend) begin
      trap_nr = `CPU_TRAP_UART;
    end else begin
      trap_nr = 4'd0;
    end
  end

endmodule

//--- rtl/cpu_alu.sv
`timescale 1ns/10ps

module cpu_alu import cpu_pkg::*; (
  input  word_t     a,
  input  word_t     b,
  input  alu_func_t func,
  input  cond_t     cond,
  output word_t     result,
  output logic      cond_true
);

  logic zero;
  logic neg;
  logic pos;

  always_comb begin
    case (func)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_NOT: result = ~a;
      // Shift amount from the low four bits of b
      ALU_SHL: result = a << b[3:0];
      ALU_SHR: result = a >> b[3:0];
      default: result = '0;
    endcase
  end

  // Three-way sign class of the result
  assign zero = (result == '0);
  assign neg  = result[15];
  assign pos  = !zero && !neg;

  always_comb begin
    case (cond)
      COND_EQ: cond_true = zero;
      COND_NE: cond_true = !zero;
      COND_LT: cond_true = neg;
      COND_LE: cond_true = zero || neg;
      COND_GT: cond_true = pos;
      COND_GE: cond_true = zero || pos;
      default: cond_true = 1'b0;
    endcase
  end

endmodule

//--- rtl/cpu_pkg.sv
package cpu_pkg;

  typedef logic [15:0] word_t;
  typedef logic [2:0] reg_idx_t;

  // Opcode lives in instr[15:12]
  typedef enum logic [3:0] {
    OP_NOP   = 4'd0,
    OP_LDI   = 4'd1,
    OP_ALU   = 4'd2,
    OP_LD    = 4'd3,
    OP_ST    = 4'd4,
    OP_SKIP  = 4'd5,
    OP_SETCR = 4'd6,
    OP_RETI  = 4'd7,
    OP_HLT   = 4'd15
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOT, ALU_SHL, ALU_SHR
  } alu_func_t;

  // Signed conditions only
  typedef enum logic [2:0] {
    COND_EQ = 3'd0,
    COND_NE = 3'd1,
    COND_LT = 3'd2,
    COND_LE = 3'd3,
    COND_GT = 3'd4,
    COND_GE = 3'd5
  } cond_t;

  typedef enum logic [1:0] {FETCH, DECODE, MEM, EXEC} cpu_state_t;

  typedef enum logic [1:0] {OPS_REGA, OPS_REGB, OPS_MDR} op_sel_t;

  typedef enum logic [1:0] {MDRS_IMM, MDRS_RAM, MDRS_ALU} mdr_sel_t;

  typedef struct packed {
    reg_idx_t  rd_a_idx;
    reg_idx_t  rd_b_idx;
    reg_idx_t  wr_idx;
    op_sel_t   op_a_sel;
    op_sel_t   op_b_sel;
    mdr_sel_t  mdr_sel;
    alu_func_t alu_func;
    cond_t     cond;
    logic      ir_load;
    logic      mdr_load;
    logic      mar_load;
    logic      reg_load;
    logic      ram_load;
    logic      re;
    logic      cond_chk;
    logic      pc_incr;
    logic      pc_skip;
    logic      cr_write;
    logic      reti;
    logic      halt;
  } ctrl_t;

endpackage

//--- include/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Start address of both program counters after reset
`define CPU_RESET_PC 16'h0000

// Handler entry point, loaded into bank 1 R7 on interrupt entry
`define CPU_IRQ_VECTOR 16'h0040

// Trap numbers as written into bank 1 R1
`define CPU_TRAP_UART 4'd1
`define CPU_TRAP_PGFAULT 4'd2

// Control register bit positions
`define CPU_CR_BANK 1
`define CPU_CR_IRQ_EN 3

`endif
